// ==== project.f ====
+incdir+design
design/hz_bus_pkg.sv
design/core_bus_if.sv
design/ahb_phase_fsm.sv
design/dph_watchdog.sv
design/ahb_master_port.sv
design/hz_cpu_2port.sv
test/tb_clkgen.sv
test/tb_ahb_slave.sv
test/tb_top.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the bus front end testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps \
	-f project.f --top-module tb_top -o Vtb_top

./obj_dir/Vtb_top > sim.log 2>&1
cat sim.log

if grep -q "^TEST RESULT: PASS$" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

// ==== test/tb_top.sv ====
// ----------------------------------------------------------
// Testbench top for the dual-port bus front end
// Directed tests over the fetch and load/store ports, each
// port answered by its own AHB-Lite memory model
// ----------------------------------------------------------

`timescale 1ns/1ps

`include "hz_bus_cfg.svh"

module tb_top;

	localparam int                 TIMEOUT  = `HZ_DPH_TIMEOUT;
	localparam int                 MAX_WAIT = 64;
	localparam logic [31:0]        ERR_ADDR = 32'hDEAD_0000;
	localparam hz_bus_pkg::hsize_t BYTE     = 3'b000;
	localparam hz_bus_pkg::hsize_t HALF     = 3'b001;
	localparam hz_bus_pkg::hsize_t WORD     = 3'b010;

	logic clk;
	logic rst_n;

	// Fetch port, core side and AHB side
	logic                i_aph_req_i, i_aph_ready_o, i_dph_ready_o, i_dph_err_o;
	hz_bus_pkg::addr_t   i_haddr_i, i_haddr_o;
	hz_bus_pkg::hsize_t  i_hsize_i, i_hsize_o;
	hz_bus_pkg::data_t   i_rdata_o, i_hrdata_i;
	hz_bus_pkg::htrans_t i_htrans_o;
	logic                i_hready_i, i_hresp_i, i_hang_o;

	// Load/store port, core side and AHB side
	logic                d_aph_req_i, d_hwrite_i, d_aph_ready_o, d_dph_ready_o, d_dph_err_o;
	hz_bus_pkg::addr_t   d_haddr_i, d_haddr_o;
	hz_bus_pkg::hsize_t  d_hsize_i, d_hsize_o;
	hz_bus_pkg::data_t   d_wdata_i, d_rdata_o, d_hwdata_o, d_hrdata_i;
	hz_bus_pkg::htrans_t d_htrans_o;
	logic                d_hwrite_o, d_hready_i, d_hresp_i, d_hang_o;

	int errors;
	int tests;

	tb_clkgen u_clkgen (.clk(clk), .rst_n(rst_n));

	hz_cpu_2port dut (.*);

	// Fetch memory never sees a write
	tb_ahb_slave imem (
		.clk(clk), .rst_n(rst_n),
		.haddr_i(i_haddr_o), .htrans_i(i_htrans_o),
		.hwrite_i(1'b0), .hwdata_i('0),
		.hready_o(i_hready_i), .hresp_o(i_hresp_i), .hrdata_o(i_hrdata_i)
	);

	tb_ahb_slave dmem (
		.clk(clk), .rst_n(rst_n),
		.haddr_i(d_haddr_o), .htrans_i(d_htrans_o),
		.hwrite_i(d_hwrite_o), .hwdata_i(d_hwdata_o),
		.hready_o(d_hready_i), .hresp_o(d_hresp_i), .hrdata_o(d_hrdata_i)
	);

	// ----------------------------------------------------------
	// Checking and reporting

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got 32'h%08h, expected 32'h%08h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic report(input string name, input int errs_before);
		tests++;
		if (errors == errs_before)
			$display("[%0d] %s: passed", tests, name);
		else
			$display("[%0d] %s: %0d mismatches", tests, name, errors - errs_before);
	endtask

	task automatic abort(input string what);
		$display("Timed out after %0d cycles waiting for %s", MAX_WAIT, what);
		$display("TEST RESULT: FAIL");
		$finish;
	endtask

	// ----------------------------------------------------------
	// Bus drivers

	// Hold the load/store request until accepted
	task automatic d_request(input logic wr, input logic [31:0] addr,
			input hz_bus_pkg::hsize_t size, input logic [31:0] wd);
		int n;
		n = 0;
		@(posedge clk);
		d_aph_req_i <= 1'b1;
		d_haddr_i   <= addr;
		d_hsize_i   <= size;
		d_hwrite_i  <= wr;
		forever begin
			@(negedge clk);
			if (d_aph_ready_o)
				break;
			n++;
			if (n == MAX_WAIT)
				abort("d_aph_ready_o");
		end
		// Address and control pass straight to the AHB side
		check("d_haddr_o", d_haddr_o, addr);
		check("d_hsize_o", 32'(d_hsize_o), 32'(size));
		check("d_hwrite_o", 32'(d_hwrite_o), 32'(wr));
		check("d_htrans_o", 32'(d_htrans_o), 32'(hz_bus_pkg::HTRANS_NSEQ));
		// Data phase starts here, write data with it
		@(posedge clk);
		d_aph_req_i <= 1'b0;
		d_wdata_i   <= wd;
	endtask

	task automatic d_complete(input logic wr, input logic [31:0] wd,
			output logic [31:0] rd, output logic err);
		int n;
		n = 0;
		forever begin
			@(negedge clk);
			if (wr)
				check("d_hwdata_o", d_hwdata_o, wd);
			if (d_dph_ready_o)
				break;
			n++;
			if (n == MAX_WAIT)
				abort("d_dph_ready_o");
		end
		rd  = d_rdata_o;
		err = d_dph_err_o;
	endtask

	task automatic d_access(input logic wr, input logic [31:0] addr,
			input hz_bus_pkg::hsize_t size, input logic [31:0] wd,
			output logic [31:0] rd, output logic err);
		d_request(wr, addr, size, wd);
		d_complete(wr, wd, rd, err);
	endtask

	// Single fetch, with the cycles spent in each phase
	task automatic i_fetch(input logic [31:0] addr, input hz_bus_pkg::hsize_t size,
			output logic [31:0] rd, output logic err, output int acc, output int dph);
		acc = 0;
		dph = 0;
		@(posedge clk);
		i_aph_req_i <= 1'b1;
		i_haddr_i   <= addr;
		i_hsize_i   <= size;
		forever begin
			@(negedge clk);
			if (i_aph_ready_o)
				break;
			acc++;
			if (acc == MAX_WAIT)
				abort("i_aph_ready_o");
		end
		// Address and control pass straight to the AHB side
		check("i_haddr_o", i_haddr_o, addr);
		check("i_hsize_o", 32'(i_hsize_o), 32'(size));
		check("i_htrans_o", 32'(i_htrans_o), 32'(hz_bus_pkg::HTRANS_NSEQ));
		@(posedge clk);
		i_aph_req_i <= 1'b0;
		forever begin
			@(negedge clk);
			dph++;
			if (i_dph_ready_o)
				break;
			if (dph == MAX_WAIT)
				abort("i_dph_ready_o");
		end
		rd  = i_rdata_o;
		err = i_dph_err_o;
	endtask

	// ----------------------------------------------------------
	// Tests

	task automatic reset_state();
		int errs;
		int n;
		errs = errors;
		n = 0;
		// Every cycle of reset, plus the first one after it
		forever begin
			@(negedge clk);
			check("i_htrans_o", 32'(i_htrans_o), 32'(hz_bus_pkg::HTRANS_IDLE));
			check("d_htrans_o", 32'(d_htrans_o), 32'(hz_bus_pkg::HTRANS_IDLE));
			check("i_dph_ready_o", 32'(i_dph_ready_o), 0);
			check("d_dph_ready_o", 32'(d_dph_ready_o), 0);
			check("i_dph_err_o", 32'(i_dph_err_o), 0);
			check("d_dph_err_o", 32'(d_dph_err_o), 0);
			check("i_hang_o", 32'(i_hang_o), 0);
			check("d_hang_o", 32'(d_hang_o), 0);
			if (rst_n)
				break;
			n++;
			if (n == MAX_WAIT)
				abort("reset release");
		end
		report("reset state", errs);
	endtask

	task automatic zero_wait_fetch();
		logic [31:0]        addr;
		logic [31:0]        word;
		logic [31:0]        rd;
		logic               err;
		hz_bus_pkg::hsize_t size;
		int                 acc;
		int                 dph;
		int                 errs;
		int                 k;
		errs = errors;
		imem.set_waits(0);
		for (k = 0; k < 4; k++) begin
			addr = 32'h0000_0100 + 32'(k * 4);
			word = $urandom;
			// Compressed fetches alternate with full words
			size = (k % 2 == 0) ? WORD : HALF;
			imem.load_word(addr, word);
			i_fetch(addr, size, rd, err, acc, dph);
			check("i_rdata_o", rd, word);
			check("i_dph_err_o", 32'(err), 0);
			// Accept in the request cycle, data one cycle later
			check("i_aph_ready_o delay", 32'(acc), 0);
			check("i_dph_ready_o delay", 32'(dph), 1);
		end
		report("zero-wait fetch", errs);
	endtask

	task automatic load_store_waits();
		logic [31:0] addr [4];
		logic [31:0] data [4];
		logic [31:0] rnd;
		logic [31:0] rd;
		logic        err;
		int          errs;
		int          k;
		errs = errors;
		for (k = 0; k < 4; k++) begin
			// Index in the address keeps the four apart
			rnd     = $urandom;
			addr[k] = {16'h2000, 4'(k), rnd[9:0], 2'b00};
			data[k] = $urandom;
			dmem.set_waits($urandom_range(3, 0));
			d_access(1'b1, addr[k], WORD, data[k], rd, err);
			check("d_dph_err_o", 32'(err), 0);
		end
		for (k = 0; k < 4; k++) begin
			dmem.set_waits($urandom_range(3, 0));
			d_access(1'b0, addr[k], WORD, 32'h0, rd, err);
			check("d_rdata_o", rd, data[k]);
			check("d_dph_err_o", 32'(err), 0);
		end
		dmem.set_waits(0);
		report("load/store with waits", errs);
	endtask

	task automatic pipelined_reads();
		logic [31:0] addr [4];
		logic [31:0] data [4];
		int          errs;
		int          c;
		errs = errors;
		imem.set_waits(0);
		for (c = 0; c < 4; c++) begin
			addr[c] = 32'h0000_0400 + 32'(c * 4);
			data[c] = $urandom;
			imem.load_word(addr[c], data[c]);
		end
		@(posedge clk);
		i_aph_req_i <= 1'b1;
		i_haddr_i   <= addr[0];
		i_hsize_i   <= WORD;
		// One accept and one completion per cycle, in order
		for (c = 0; c < 5; c++) begin
			@(negedge clk);
			check("i_aph_ready_o", 32'(i_aph_ready_o), 32'(c < 4));
			check("i_dph_ready_o", 32'(i_dph_ready_o), 32'(c > 0));
			if (c > 0)
				check("i_rdata_o", i_rdata_o, data[c - 1]);
			@(posedge clk);
			if (c < 3)
				i_haddr_i <= addr[c + 1];
			else
				i_aph_req_i <= 1'b0;
		end
		report("pipelined fetch", errs);
	endtask

	task automatic error_response();
		logic [31:0] rd;
		logic        err;
		int          acc;
		int          dph;
		int          errs;
		errs = errors;
		dmem.set_waits(0);
		d_access(1'b0, ERR_ADDR, WORD, 32'h0, rd, err);
		check("d_dph_err_o", 32'(err), 1);
		// Following access is clean again
		d_access(1'b0, 32'h2000_0800, HALF, 32'h0, rd, err);
		check("d_dph_err_o", 32'(err), 0);

		// Same on the fetch port
		imem.set_waits(0);
		i_fetch(ERR_ADDR, WORD, rd, err, acc, dph);
		check("i_dph_err_o", 32'(err), 1);
		i_fetch(32'h0000_0100, WORD, rd, err, acc, dph);
		check("i_dph_err_o", 32'(err), 0);
		report("error response", errs);
	endtask

	task automatic hang_status();
		logic [31:0] rd;
		logic        err;
		int          acc;
		int          dph;
		int          errs;
		int          j;
		errs = errors;
		dmem.set_waits(TIMEOUT + 4);
		d_request(1'b0, 32'h2000_0040, BYTE, 32'h0);
		j = 0;
		forever begin
			@(negedge clk);
			j++;
			// Edges ending j-1 stall cycles lie behind
			check("d_hang_o", 32'(d_hang_o), 32'(j - 1 >= TIMEOUT));
			if (d_dph_ready_o)
				break;
			if (j == MAX_WAIT)
				abort("d_dph_ready_o in long stall");
		end
		check("stall length", 32'(j - 1), 32'(TIMEOUT + 4));
		@(negedge clk);
		check("d_hang_o", 32'(d_hang_o), 0);

		// Short stall stays below the limit
		dmem.set_waits(TIMEOUT - 2);
		d_request(1'b0, 32'h2000_0044, HALF, 32'h0);
		j = 0;
		forever begin
			@(negedge clk);
			j++;
			check("d_hang_o", 32'(d_hang_o), 0);
			if (d_dph_ready_o)
				break;
			if (j == MAX_WAIT)
				abort("d_dph_ready_o in short stall");
		end
		@(negedge clk);
		check("d_hang_o", 32'(d_hang_o), 0);
		dmem.set_waits(0);

		// Long stall on the fetch port
		imem.set_waits(TIMEOUT + 4);
		i_fetch(32'h0000_0200, WORD, rd, err, acc, dph);
		check("i_dph_ready_o delay", 32'(dph), 32'(TIMEOUT + 5));
		check("i_hang_o", 32'(i_hang_o), 1);
		@(negedge clk);
		check("i_hang_o", 32'(i_hang_o), 0);
		imem.set_waits(0);
		report("hang status", errs);
	endtask

	// ----------------------------------------------------------
	// Sequence

	initial begin
		errors = 0;
		tests  = 0;
		void'($urandom(32'h6a7a_7779));
		i_aph_req_i = 1'b0;
		i_haddr_i   = '0;
		i_hsize_i   = WORD;
		d_aph_req_i = 1'b0;
		d_haddr_i   = '0;
		d_hsize_i   = WORD;
		d_hwrite_i  = 1'b0;
		d_wdata_i   = '0;

		reset_state();
		zero_wait_fetch();
		load_store_waits();
		pipelined_reads();
		error_response();
		hang_status();

		$display("Tests run: %0d, failing checks: %0d", tests, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== test/tb_ahb_slave.sv ====
// ----------------------------------------------------------
// AHB-Lite memory model
// Word store with a programmable wait count per data phase
// and a two-cycle error response on one fixed address
// ----------------------------------------------------------

`timescale 1ns/1ps

module tb_ahb_slave (
	input  logic                clk,
	input  logic                rst_n,
	input  hz_bus_pkg::addr_t   haddr_i,
	input  hz_bus_pkg::htrans_t htrans_i,
	input  logic                hwrite_i,
	input  hz_bus_pkg::data_t   hwdata_i,
	output logic                hready_o,
	output logic                hresp_o,
	output hz_bus_pkg::data_t   hrdata_o
);

	localparam hz_bus_pkg::addr_t ERR_ADDR = 32'hDEAD_0000;

	// Sparse word store
	hz_bus_pkg::data_t mem [hz_bus_pkg::addr_t];
	int                waits = 0;

	// Data phase in progress
	logic              dph_valid;
	logic              dph_write;
	logic              dph_err;
	logic              err_first;
	hz_bus_pkg::addr_t dph_addr;
	int                wait_left;

	task automatic set_waits(input int n);
		waits = n;
	endtask

	task automatic load_word(input hz_bus_pkg::addr_t a, input hz_bus_pkg::data_t d);
		mem[a] = d;
	endtask

	// Unwritten words read back a pattern of their address
	function automatic hz_bus_pkg::data_t read_word(input hz_bus_pkg::addr_t a);
		if (mem.exists(a))
			return mem[a];
		return a ^ 32'hC3A5_5A3C;
	endfunction

	// Low for each wait state and for the first error cycle
	assign hready_o = !(dph_valid && (wait_left != 0 || err_first));
	assign hresp_o  = dph_valid && dph_err;

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dph_valid <= 1'b0;
			dph_write <= 1'b0;
			dph_err   <= 1'b0;
			err_first <= 1'b0;
			dph_addr  <= '0;
			wait_left <= 0;
			hrdata_o  <= '0;
		end else if (hready_o) begin
			// Completing write lands before the next read
			if (dph_valid && dph_write && !dph_err)
				mem[dph_addr] = hwdata_i;
			dph_valid <= (htrans_i == hz_bus_pkg::HTRANS_NSEQ);
			dph_addr  <= haddr_i;
			dph_write <= hwrite_i;
			dph_err   <= (haddr_i == ERR_ADDR);
			err_first <= (haddr_i == ERR_ADDR);
			wait_left <= (haddr_i == ERR_ADDR) ? 0 : waits;
			hrdata_o  <= read_word(haddr_i);
		end else begin
			if (wait_left != 0)
				wait_left <= wait_left - 1;
			err_first <= 1'b0;
		end
	end

endmodule

// ==== test/tb_clkgen.sv ====
// ----------------------------------------------------------
// Testbench clock and reset
// 40 ns clock, active-low reset held for the first cycles
// ----------------------------------------------------------

`timescale 1ns/1ps

module tb_clkgen #(
	parameter int HALF_PERIOD = 20,
	parameter int RST_CYCLES  = 8
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

	// Released on the edge ending the last reset cycle
	initial begin
		rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

// ==== design/hz_cpu_2port.sv ====
// ----------------------------------------------------------
// Dual-port bus front end
// Instruction fetch and load/store request buses of the
// core, each driving its own AHB-Lite master port
// ----------------------------------------------------------

`timescale 1ns/1ps

module hz_cpu_2port (
	input  logic                clk,
	input  logic                rst_n,

	// Instruction fetch, core side
	input  logic                i_aph_req_i,
	input  hz_bus_pkg::addr_t   i_haddr_i,
	input  hz_bus_pkg::hsize_t  i_hsize_i,
	output logic                i_aph_ready_o,
	output logic                i_dph_ready_o,
	output logic                i_dph_err_o,
	output hz_bus_pkg::data_t   i_rdata_o,

	// Load/store, core side
	input  logic                d_aph_req_i,
	input  hz_bus_pkg::addr_t   d_haddr_i,
	input  hz_bus_pkg::hsize_t  d_hsize_i,
	input  logic                d_hwrite_i,
	input  hz_bus_pkg::data_t   d_wdata_i,
	output logic                d_aph_ready_o,
	output logic                d_dph_ready_o,
	output logic                d_dph_err_o,
	output hz_bus_pkg::data_t   d_rdata_o,

	// Instruction AHB-Lite master, read-only
	output hz_bus_pkg::addr_t   i_haddr_o,
	output hz_bus_pkg::htrans_t i_htrans_o,
	output hz_bus_pkg::hsize_t  i_hsize_o,
	input  logic                i_hready_i,
	input  logic                i_hresp_i,
	input  hz_bus_pkg::data_t   i_hrdata_i,
	output logic                i_hang_o,

	// Load/store AHB-Lite master
	output hz_bus_pkg::addr_t   d_haddr_o,
	output hz_bus_pkg::htrans_t d_htrans_o,
	output hz_bus_pkg::hsize_t  d_hsize_o,
	output logic                d_hwrite_o,
	output hz_bus_pkg::data_t   d_hwdata_o,
	input  logic                d_hready_i,
	input  logic                d_hresp_i,
	input  hz_bus_pkg::data_t   d_hrdata_i,
	output logic                d_hang_o
);

	core_bus_if i_bus ();
	core_bus_if d_bus ();

	// ----------------------------------------------------------
	// Instruction port

	assign i_bus.aph_req = i_aph_req_i;
	assign i_bus.haddr   = i_haddr_i;
	assign i_bus.hsize   = i_hsize_i;
	// Fetch never writes
	assign i_bus.hwrite  = 1'b0;
	assign i_bus.wdata   = '0;

	assign i_aph_ready_o = i_bus.aph_ready;
	assign i_dph_ready_o = i_bus.dph_ready;
	assign i_dph_err_o   = i_bus.dph_err;
	assign i_rdata_o     = i_bus.rdata;

	// hwrite/hwdata tied low inside, fabric ties its own
	ahb_master_port #(
		.HAS_WRITE (1'b0)
	) u_iport (
		.clk      (clk),
		.rst_n    (rst_n),
		.bus      (i_bus.bridge),
		.haddr_o  (i_haddr_o),
		.htrans_o (i_htrans_o),
		.hsize_o  (i_hsize_o),
		.hwrite_o (),
		.hwdata_o (),
		.hready_i (i_hready_i),
		.hresp_i  (i_hresp_i),
		.hrdata_i (i_hrdata_i),
		.hang_o   (i_hang_o)
	);

	// ----------------------------------------------------------
	// Load/store port

	assign d_bus.aph_req = d_aph_req_i;
	assign d_bus.haddr   = d_haddr_i;
	assign d_bus.hsize   = d_hsize_i;
	assign d_bus.hwrite  = d_hwrite_i;
	assign d_bus.wdata   = d_wdata_i;

	assign d_aph_ready_o = d_bus.aph_ready;
	assign d_dph_ready_o = d_bus.dph_ready;
	assign d_dph_err_o   = d_bus.dph_err;
	assign d_rdata_o     = d_bus.rdata;

	ahb_master_port #(
		.HAS_WRITE (1'b1)
	) u_dport (
		.clk      (clk),
		.rst_n    (rst_n),
		.bus      (d_bus.bridge),
		.haddr_o  (d_haddr_o),
		.htrans_o (d_htrans_o),
		.hsize_o  (d_hsize_o),
		.hwrite_o (d_hwrite_o),
		.hwdata_o (d_hwdata_o),
		.hready_i (d_hready_i),
		.hresp_i  (d_hresp_i),
		.hrdata_i (d_hrdata_i),
		.hang_o   (d_hang_o)
	);

endmodule

// ==== design/ahb_master_port.sv ====
// ----------------------------------------------------------
// AHB-Lite master port
// Bridges one core-side request bus to a pipelined AHB-Lite
// master, with phase tracking and a stall watchdog
// ----------------------------------------------------------

`timescale 1ns/1ps

module ahb_master_port #(
	parameter bit HAS_WRITE = 1'b1
) (
	input  logic                clk,
	input  logic                rst_n,
	core_bus_if.bridge          bus,

	// AHB-Lite master
	output hz_bus_pkg::addr_t   haddr_o,
	output hz_bus_pkg::htrans_t htrans_o,
	output hz_bus_pkg::hsize_t  hsize_o,
	output logic                hwrite_o,
	output hz_bus_pkg::data_t   hwdata_o,
	input  logic                hready_i,
	input  logic                hresp_i,
	input  hz_bus_pkg::data_t   hrdata_i,

	// Slave stalled past the timeout
	output logic                hang_o
);

	logic dph_active;

	// ----------------------------------------------------------
	// Address phase

	// Request held until accepted, so pass straight through
	assign htrans_o = bus.aph_req ? hz_bus_pkg::HTRANS_NSEQ : hz_bus_pkg::HTRANS_IDLE;
	assign haddr_o  = bus.haddr;
	assign hsize_o  = bus.hsize;

	// ----------------------------------------------------------
	// Data phase

	// Write path only on ports that can store
	generate
		if (HAS_WRITE) begin : g_write
			assign hwrite_o = bus.hwrite;
			assign hwdata_o = bus.wdata;
		end else begin : g_no_write
			assign hwrite_o = 1'b0;
			assign hwdata_o = '0;
		end
	endgenerate

	// Read data qualified by dph_ready at the core
	assign bus.rdata = hrdata_i;

	// ----------------------------------------------------------
	// Phase control and watchdog

	ahb_phase_fsm u_fsm (
		.clk          (clk),
		.rst_n        (rst_n),
		.aph_req_i    (bus.aph_req),
		.hready_i     (hready_i),
		.hresp_i      (hresp_i),
		.aph_ready_o  (bus.aph_ready),
		.dph_ready_o  (bus.dph_ready),
		.dph_err_o    (bus.dph_err),
		.dph_active_o (dph_active)
	);

	dph_watchdog u_wdog (
		.clk          (clk),
		.rst_n        (rst_n),
		.dph_active_i (dph_active),
		.hready_i     (hready_i),
		.hang_o       (hang_o)
	);

endmodule

// ==== design/dph_watchdog.sv ====
// ----------------------------------------------------------
// Data-phase watchdog
// Counts consecutive stalled data-phase cycles and raises
// a registered hang flag when a slave stalls too long
// ----------------------------------------------------------

`timescale 1ns/1ps

`include "hz_bus_cfg.svh"

module dph_watchdog (
	input  logic clk,
	input  logic rst_n,
	input  logic dph_active_i,
	input  logic hready_i,
	output logic hang_o
);

	// Count saturates at the timeout
	localparam logic [`HZ_W_WDOG-1:0] LIMIT = (`HZ_W_WDOG)'(`HZ_DPH_TIMEOUT);

	logic [`HZ_W_WDOG-1:0] cnt_q;
	logic [`HZ_W_WDOG-1:0] cnt_d;
	logic                  stall;

	// Wait state inside an outstanding data phase
	assign stall = dph_active_i && !hready_i;

	// Completion or idle bus clears the count
	always_comb begin
		if (!stall)
			cnt_d = '0;
		else if (cnt_q == LIMIT)
			cnt_d = cnt_q;
		else
			cnt_d = cnt_q + 1'b1;
	end

	// Hang set on the edge ending the LIMIT-th stall cycle,
	// cleared on the edge ending the completing cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt_q  <= '0;
			hang_o <= 1'b0;
		end else begin
			cnt_q  <= cnt_d;
			hang_o <= (cnt_d == LIMIT);
		end
	end

endmodule

// ==== design/ahb_phase_fsm.sv ====
// ----------------------------------------------------------
// AHB phase tracker
// Follows the address and data phases of one master port
// and decodes the accept, completion and error strobes
// ----------------------------------------------------------

`timescale 1ns/1ps

module ahb_phase_fsm (
	input  logic clk,
	input  logic rst_n,
	input  logic aph_req_i,
	input  logic hready_i,
	input  logic hresp_i,
	output logic aph_ready_o,
	output logic dph_ready_o,
	output logic dph_err_o,
	output logic dph_active_o
);

	hz_bus_pkg::dph_state_t state_q;
	hz_bus_pkg::dph_state_t state_d;

	// ----------------------------------------------------------
	// Next state

	// Nothing moves while the slave holds hready low
	always_comb begin
		state_d = state_q;
		case (state_q)
			hz_bus_pkg::DPH_IDLE: begin
				// Accepted address phase opens a data phase
				if (hready_i && aph_req_i)
					state_d = hz_bus_pkg::DPH_ACTIVE;
			end
			hz_bus_pkg::DPH_ACTIVE: begin
				// Completion with no new request behind it
				if (hready_i && !aph_req_i)
					state_d = hz_bus_pkg::DPH_IDLE;
			end
			default: state_d = hz_bus_pkg::DPH_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state_q <= hz_bus_pkg::DPH_IDLE;
		else
			state_q <= state_d;
	end

	// ----------------------------------------------------------
	// Strobes to the core

	assign dph_active_o = (state_q == hz_bus_pkg::DPH_ACTIVE);

	// Same-cycle accept, no register in the path
	assign aph_ready_o = aph_req_i && hready_i;

	// Data phase ends on the first hready-high cycle
	assign dph_ready_o = dph_active_o && hready_i;

	// Error only flagged in the final cycle of the response
	assign dph_err_o = dph_active_o && hready_i && hresp_i;

endmodule

// ==== design/core_bus_if.sv ====
// ----------------------------------------------------------
// Core-side bus port
// Split address/data phase request bus between the core
// and one AHB-Lite bridge port
// ----------------------------------------------------------

`timescale 1ns/1ps

interface core_bus_if;

	// Address phase request, held until aph_ready
	logic              aph_req;
	hz_bus_pkg::addr_t haddr;
	hz_bus_pkg::hsize_t hsize;
	logic              hwrite;

	// Write data, presented in the data phase
	hz_bus_pkg::data_t wdata;

	// Strobes back to the core
	logic              aph_ready;
	logic              dph_ready;
	logic              dph_err;

	// Read data, valid with dph_ready
	hz_bus_pkg::data_t rdata;

	// Core drives the request side
	modport core (
		output aph_req, haddr, hsize, hwrite, wdata,
		input  aph_ready, dph_ready, dph_err, rdata
	);

	// Bridge answers with strobes and read data
	modport bridge (
		input  aph_req, haddr, hsize, hwrite, wdata,
		output aph_ready, dph_ready, dph_err, rdata
	);

endinterface

// ==== design/hz_bus_pkg.sv ====
// ----------------------------------------------------------
// Bus front end types
// Vector types for address, data and size, plus the AHB
// htrans encoding and the data-phase state of a port
// ----------------------------------------------------------

`include "hz_bus_cfg.svh"

package hz_bus_pkg;

	// Bus payload vectors
	typedef logic [`HZ_W_ADDR-1:0] addr_t;
	typedef logic [`HZ_W_DATA-1:0] data_t;

	// AHB transfer size, byte/half/word
	typedef logic [2:0] hsize_t;

	// Only single transfers, so SEQ and BUSY never appear
	typedef enum logic [1:0] {
		HTRANS_IDLE = 2'b00,
		HTRANS_NSEQ = 2'b10
	} htrans_t;

	// Whether a data phase is outstanding on the port
	typedef enum logic {
		DPH_IDLE   = 1'b0,
		DPH_ACTIVE = 1'b1
	} dph_state_t;

endpackage

// ==== design/hz_bus_cfg.svh ====
// ----------------------------------------------------------
// Bus front end configuration
// Widths of the core-side and AHB-Lite buses, and the limit
// of the data-phase wait-state watchdog
// ----------------------------------------------------------

`ifndef HZ_BUS_CFG_SVH
`define HZ_BUS_CFG_SVH

// Bus widths
`define HZ_W_ADDR 32
`define HZ_W_DATA 32

// Consecutive hready-low data-phase cycles before hang
`define HZ_DPH_TIMEOUT 16

// Watchdog counter width, must hold HZ_DPH_TIMEOUT
`define HZ_W_WDOG 5

`endif
